// File: build.f
+incdir+verif
verilog/cart_pkg.sv
verilog/host_pkg.sv
verilog/rom_header_decode.sv
verilog/cheat_code_loader.sv
verilog/backup_ram_sequencer.sv
verilog/cart_control_top.sv
verif/tb_cart_control.sv

// File: Makefile
# Verilator build and run for the cartridge control testbench

VERILATOR ?= verilator
TOP       ?= tb_cart_control
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard verif/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/tb_cart_ref.svh
`ifndef TB_CART_REF_SVH
`define TB_CART_REF_SVH

// ==============================
// Reference model
// ==============================

// Size code counts in 1 KB steps
function automatic cart_mask_t ref_mask(input size_code_t code);
	logic [31:0] bytes;
	bytes = 32'd1024 << code;
	return cart_mask_t'(bytes - 32'd1);
endfunction

// No save RAM when the code is zero
function automatic cart_mask_t ref_ram_mask(input size_code_t code);
	if (code == 4'd0) begin
		return '0;
	end
	return ref_mask(code);
endfunction

function automatic rom_type_t ref_rom_type(input rom_layout_t lay, input logic [7:0] hdr_type);
	case (lay)
		LAYOUT_AUTO:    return hdr_type;
		LAYOUT_HIROM:   return 8'd1;
		LAYOUT_EXHIROM: return 8'd2;
		default:        return 8'd0;
	endcase
endfunction

function automatic logic ref_pal(input video_region_t sel, input logic hdr_bit);
	if (sel == REGION_AUTO) begin
		return hdr_bit;
	end
	return (sel == REGION_PAL);
endfunction

// ROM size byte of a forced layout, behind the 512-byte copier header
function automatic dl_addr_t ref_size_addr(input rom_layout_t lay);
	case (lay)
		LAYOUT_HIROM:   return 25'h00FFD6 + 25'h200;
		LAYOUT_EXHIROM: return 25'h40FFD6 + 25'h200;
		default:        return 25'h007FD6 + 25'h200;
	endcase
endfunction

// Word pairs land low half first: flags, address, compare, replace
function automatic cheat_code_t ref_code(input dl_word_t w [8]);
	return {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
endfunction

// ==============================
// Compare tasks
// ==============================

task automatic check_mask(input string name, input cart_mask_t expected, input cart_mask_t actual);
	if (actual !== expected) begin
		fail_run($sformatf("CHECK FAILED %s: expected 0x%h, actual 0x%h", name, expected, actual));
	end
endtask

task automatic check_rom_type(input string name, input rom_type_t expected, input rom_type_t actual);
	if (actual !== expected) begin
		fail_run($sformatf("CHECK FAILED %s: expected 0x%h, actual 0x%h", name, expected, actual));
	end
endtask

task automatic check_code(input string name, input cheat_code_t expected, input cheat_code_t actual);
	if (actual !== expected) begin
		fail_run($sformatf("CHECK FAILED %s: expected 0x%h, actual 0x%h", name, expected, actual));
	end
endtask

task automatic check_lba(input string name, input sd_lba_t expected, input sd_lba_t actual);
	if (actual !== expected) begin
		fail_run($sformatf("CHECK FAILED %s: expected 0x%h, actual 0x%h", name, expected, actual));
	end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
	if (actual !== expected) begin
		fail_run($sformatf("CHECK FAILED %s: expected 0x%h, actual 0x%h", name, expected, actual));
	end
endtask

`endif

// File: verif/tb_cart_control.sv
`timescale 1ns/1ps

module tb_cart_control
	import cart_pkg::*;
	import host_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 10;
	localparam int HEADER_RUNS = 8;
	localparam int CHEAT_RECORDS = 4;
	// 4 KB save RAM gives eight sectors
	localparam size_code_t BK_RAM_CODE = 4'd2;
	localparam int BK_SECTORS = 8;
	localparam int SECTOR_MAX_CYCLES = 8 + 20 + 3;
	localparam int TEST_CYCLES = RESET_CYCLES + 16 * 12 + CHEAT_RECORDS * 18
		+ 3 * BK_SECTORS * SECTOR_MAX_CYCLES + 40;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 200;

	logic clk_sys, reset, dl_active, dl_wr, img_mounted, img_readonly, bsram_write;
	logic osd_status, load_req, save_req, autosave_en, sd_ack;
	dl_index_t dl_index;
	dl_addr_t dl_addr;
	dl_word_t dl_data;
	rom_layout_t layout;
	video_region_t region_sel;
	logic [63:0] img_size;
	rom_type_t rom_type;
	cart_mask_t rom_mask, ram_mask;
	cheat_code_t cheat_code;
	sd_lba_t sd_lba;
	logic pal, code_valid, sd_rd, sd_wr, bk_busy, bk_loading, bk_ena, bk_pending;
	logic core_reset, led_user;

	integer seed = 76770;
	cart_mask_t exp_rom_mask, exp_ram_mask;
	rom_type_t exp_rom_type;
	cheat_code_t exp_code;
	logic exp_pal = 1'b0;
	logic code_phase = 1'b0;
	int valid_count = 0;
	int exp_valid_count = 0;
	event header_ready, code_ready;
	sd_lba_t lba_log[$];
	logic read_log[$];

	cart_control_top uut (.*);

	initial clk_sys = 1'b0;
	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

`include "tb_cart_ref.svh"

	// ==============================
	// Stimulus helpers
	// ==============================

	task automatic write_word(input dl_addr_t addr, input dl_word_t data);
		@(negedge clk_sys);
		dl_addr = addr;
		dl_data = data;
		dl_wr = 1'b1;
		@(negedge clk_sys);
		dl_wr = 1'b0;
	endtask

	task automatic header_run(input rom_layout_t lay, input video_region_t sel,
		input logic [7:0] size_byte);
		logic [7:0] type_byte;
		logic region_bit;
		dl_word_t filler;
		size_code_t rom_code;
		size_code_t ram_code;
		dl_addr_t hdr;
		type_byte = 8'($random(seed));
		region_bit = 1'($random(seed));
		filler = 16'($random(seed));
		rom_code = 4'd12;
		ram_code = 4'd0;
		layout = lay;
		@(negedge clk_sys);
		dl_index = 8'd0;
		dl_active = 1'b1;
		region_sel = sel;
		write_word(25'd0, {type_byte, size_byte});
		write_word(25'd2, {filler[15:9], region_bit, filler[7:0]});
		if (lay == LAYOUT_AUTO && size_byte != 8'd0) begin
			rom_code = size_byte[3:0];
			ram_code = size_byte[7:4];
		end
		if (lay == LAYOUT_LOROM || lay == LAYOUT_HIROM || lay == LAYOUT_EXHIROM) begin
			hdr = ref_size_addr(lay);
			write_word(hdr, {size_byte, filler[7:0]});
			write_word(hdr + 25'd2, {filler[15:4], size_byte[7:4]});
			rom_code = size_byte[3:0];
			ram_code = size_byte[7:4];
		end
		// Region must not move while the download runs
		check_bit("pal", exp_pal, pal);
		@(negedge clk_sys);
		dl_active = 1'b0;
		repeat (2) @(negedge clk_sys);
		exp_rom_mask = ref_mask(rom_code);
		exp_ram_mask = ref_ram_mask(ram_code);
		exp_rom_type = ref_rom_type(lay, type_byte);
		exp_pal = ref_pal(sel, region_bit);
		-> header_ready;
	endtask

	task automatic cheat_record(input int rec);
		dl_word_t w [8];
		for (int i = 0; i < 8; i++) begin
			w[i] = 16'($random(seed));
		end
		for (int i = 0; i < 8; i++) begin
			write_word(dl_addr_t'(rec * 16 + 2 * i), w[i]);
		end
		@(negedge clk_sys);
		exp_code = ref_code(w);
		exp_valid_count = rec + 1;
		-> code_ready;
	endtask

	// Waits on bk_busy, optionally holding the core in reset meanwhile
	task automatic wait_busy(input logic level, input logic hold_reset, input string what);
		int n;
		n = 0;
		while (bk_busy !== level) begin
			if (hold_reset) begin
				check_bit("core_reset", 1'b1, core_reset);
			end
			@(negedge clk_sys);
			n++;
			if (n > BK_SECTORS * SECTOR_MAX_CYCLES + 20) begin
				fail_run(what);
			end
		end
	endtask

	task automatic check_transfers(input logic reading);
		sd_lba_t last;
		last = sd_lba_t'(ref_ram_mask(BK_RAM_CODE) >> 9);
		if (lba_log.size() != int'(last) + 1) begin
			fail_run($sformatf("Expected %0d SD sectors but %0d were requested",
				int'(last) + 1, lba_log.size()));
		end
		for (int i = 0; i < lba_log.size(); i++) begin
			check_lba("sd_lba", sd_lba_t'(i), lba_log[i]);
			check_bit("sd_rd", reading, read_log[i]);
		end
		lba_log.delete();
		read_log.delete();
	endtask

	// ==============================
	// Checkers and SD image model
	// ==============================

	always @(header_ready) begin
		check_mask("rom_mask", exp_rom_mask, rom_mask);
		check_mask("ram_mask", exp_ram_mask, ram_mask);
		check_rom_type("rom_type", exp_rom_type, rom_type);
		check_bit("pal", exp_pal, pal);
	end

	always @(code_ready) begin
		check_code("cheat_code", exp_code, cheat_code);
		if (valid_count != exp_valid_count) begin
			fail_run($sformatf("code_valid pulsed %0d times for %0d records",
				valid_count, exp_valid_count));
		end
	end

	always @(negedge clk_sys) begin
		if (code_valid) begin
			valid_count++;
		end
	end

	// Cheat downloads leave the core running and the LED dark
	always @(posedge clk_sys) begin
		if (code_phase) begin
			check_bit("core_reset", 1'b0, core_reset);
			check_bit("led_user", 1'b0, led_user);
		end
	end

	always begin
		@(negedge clk_sys);
		if (sd_rd || sd_wr) begin
			if (sd_rd && sd_wr) begin
				fail_run("SD read and write were requested together");
			end
			lba_log.push_back(sd_lba);
			read_log.push_back(sd_rd);
			repeat (1 + $unsigned($random(seed)) % 8) @(negedge clk_sys);
			sd_ack = 1'b1;
			repeat (4 + $unsigned($random(seed)) % 17) @(negedge clk_sys);
			if (sd_rd || sd_wr) begin
				fail_run("SD request stayed high after it was acknowledged");
			end
			sd_ack = 1'b0;
		end
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		fail_run("Simulation timed out before the tests finished");
	end

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		reset = 1'b1;
		{dl_active, dl_wr, img_mounted, img_readonly, bsram_write} = '0;
		{osd_status, load_req, save_req, autosave_en, sd_ack} = '0;
		dl_index = '0;
		dl_addr = '0;
		dl_data = '0;
		layout = LAYOUT_AUTO;
		region_sel = REGION_AUTO;
		img_size = '0;
		repeat (RESET_CYCLES) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		check_bit("sd_rd", 1'b0, sd_rd);
		check_bit("sd_wr", 1'b0, sd_wr);
		check_bit("bk_busy", 1'b0, bk_busy);
		check_bit("bk_loading", 1'b0, bk_loading);
		check_bit("bk_pending", 1'b0, bk_pending);
		check_bit("code_valid", 1'b0, code_valid);
		check_bit("pal", 1'b0, pal);

		// Auto layout, first run takes the default sizes, second has no RAM
		for (int r = 0; r < HEADER_RUNS; r++) begin
			if (r == 0) begin
				header_run(LAYOUT_AUTO, REGION_AUTO, 8'd0);
			end else if (r == 1) begin
				header_run(LAYOUT_AUTO, REGION_AUTO, {4'd0, 4'($random(seed))});
			end else begin
				header_run(LAYOUT_AUTO, REGION_AUTO, 8'($random(seed)));
			end
		end
		header_run(LAYOUT_NO_HEADER, REGION_AUTO, 8'($random(seed)));
		header_run(LAYOUT_LOROM, REGION_AUTO, 8'($random(seed)));
		header_run(LAYOUT_HIROM, REGION_AUTO, 8'($random(seed)));
		header_run(LAYOUT_EXHIROM, REGION_AUTO, 8'($random(seed)));
		header_run(LAYOUT_AUTO, REGION_PAL, 8'($random(seed)));
		header_run(LAYOUT_AUTO, REGION_NTSC, 8'($random(seed)));

		@(negedge clk_sys);
		dl_index = CODE_INDEX;
		dl_active = 1'b1;
		code_phase = 1'b1;
		for (int r = 0; r < CHEAT_RECORDS; r++) begin
			cheat_record(r);
		end
		dl_active = 1'b0;
		code_phase = 1'b0;

		// Read-only image never gets a transfer
		img_mounted = 1'b1;
		img_readonly = 1'b1;
		img_size = 64'h2000;
		header_run(LAYOUT_AUTO, REGION_AUTO, {BK_RAM_CODE, 4'd8});
		repeat (20) @(negedge clk_sys);
		check_bit("bk_ena", 1'b0, bk_ena);
		if (lba_log.size() != 0) begin
			fail_run("SD request was raised for a read-only image");
		end

		img_readonly = 1'b0;
		header_run(LAYOUT_AUTO, REGION_AUTO, {BK_RAM_CODE, 4'd8});
		wait_busy(1'b1, 1'b0, "Save RAM load never started after the download");
		check_bit("bk_loading", 1'b1, bk_loading);
		wait_busy(1'b0, 1'b1, "Save RAM load never finished");
		check_bit("bk_loading", 1'b0, bk_loading);
		check_transfers(1'b1);
		check_bit("core_reset", 1'b0, core_reset);

		// Autosave once the OSD opens
		autosave_en = 1'b1;
		bsram_write = 1'b1;
		@(negedge clk_sys);
		bsram_write = 1'b0;
		check_bit("bk_pending", 1'b1, bk_pending);
		check_bit("led_user", 1'b1, led_user);
		osd_status = 1'b1;
		wait_busy(1'b1, 1'b0, "Autosave never started");
		check_bit("bk_loading", 1'b0, bk_loading);
		wait_busy(1'b0, 1'b0, "Autosave never finished");
		check_transfers(1'b0);
		check_bit("bk_pending", 1'b0, bk_pending);
		check_bit("led_user", 1'b0, led_user);

		osd_status = 1'b0;
		save_req = 1'b1;
		wait_busy(1'b1, 1'b0, "Manual save never started");
		wait_busy(1'b0, 1'b0, "Manual save never finished");
		save_req = 1'b0;
		check_transfers(1'b0);

		$display("All checks passed");
		$finish;
	end

endmodule

// File: verilog/cart_control_top.sv
`timescale 1ns/1ps

module cart_control_top
	import cart_pkg::*;
	import host_pkg::*;
(
	input  logic          clk_sys,
	input  logic          reset,
	input  logic          dl_active,
	input  dl_index_t     dl_index,
	input  dl_addr_t      dl_addr,
	input  dl_word_t      dl_data,
	input  logic          dl_wr,
	input  rom_layout_t   layout,
	input  video_region_t region_sel,
	input  logic          img_mounted,
	input  logic          img_readonly,
	input  logic [63:0]   img_size,
	input  logic          bsram_write,
	input  logic          osd_status,
	input  logic          load_req,
	input  logic          save_req,
	input  logic          autosave_en,
	input  logic          sd_ack,
	output rom_type_t     rom_type,
	output cart_mask_t    rom_mask,
	output cart_mask_t    ram_mask,
	output logic          pal,
	output cheat_code_t   cheat_code,
	output logic          code_valid,
	output logic          sd_rd,
	output logic          sd_wr,
	output sd_lba_t       sd_lba,
	output logic          bk_busy,
	output logic          bk_loading,
	output logic          bk_ena,
	output logic          bk_pending,
	output logic          core_reset,
	output logic          led_user
);

	logic cart_download;
	logic code_download;

	// ==============================
	// Download split
	// ==============================

	assign code_download = dl_active & (dl_index == CODE_INDEX);
	assign cart_download = dl_active & (dl_index != CODE_INDEX);

	rom_header_decode u_header (
		.clk_sys(clk_sys), .reset(reset), .cart_download(cart_download), .dl_wr(dl_wr),
		.dl_addr(dl_addr), .dl_data(dl_data), .layout(layout), .region_sel(region_sel),
		.rom_type(rom_type), .rom_mask(rom_mask), .ram_mask(ram_mask), .pal(pal)
	);

	cheat_code_loader u_cheat (
		.clk_sys(clk_sys), .reset(reset), .code_download(code_download), .dl_wr(dl_wr),
		.dl_addr(dl_addr), .dl_data(dl_data), .cheat_code(cheat_code),
		.code_valid(code_valid)
	);

	backup_ram_sequencer u_backup (
		.clk_sys(clk_sys), .reset(reset), .cart_download(cart_download),
		.img_mounted(img_mounted), .img_readonly(img_readonly), .bsram_write(bsram_write),
		.osd_status(osd_status), .load_req(load_req), .save_req(save_req),
		.autosave_en(autosave_en), .img_size(img_size), .ram_mask(ram_mask), .sd_ack(sd_ack),
		.sd_rd(sd_rd), .sd_wr(sd_wr), .sd_lba(sd_lba), .bk_busy(bk_busy),
		.bk_loading(bk_loading), .bk_ena(bk_ena), .bk_pending(bk_pending)
	);

	// Core stays in reset while the cartridge or its save is loading
	assign core_reset = reset | cart_download | bk_loading;
	// LED shows a download or unsaved changes under autosave
	assign led_user = cart_download | (autosave_en & bk_pending);

endmodule

// File: verilog/backup_ram_sequencer.sv
`timescale 1ns/1ps

module backup_ram_sequencer
	import cart_pkg::*;
	import host_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        cart_download,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic        bsram_write,
	input  logic        osd_status,
	input  logic        load_req,
	input  logic        save_req,
	input  logic        autosave_en,
	input  logic [63:0] img_size,
	input  cart_mask_t  ram_mask,
	input  logic        sd_ack,
	output logic        sd_rd,
	output logic        sd_wr,
	output sd_lba_t     sd_lba,
	output logic        bk_busy,
	output logic        bk_loading,
	output logic        bk_ena,
	output logic        bk_pending
);

	bk_state_t state;
	logic      old_download;
	logic      load_s;
	logic      load_d;
	logic      save_s;
	logic      save_d;
	logic      ack_d;
	logic      save_eff;
	logic      load_rise;
	logic      save_rise;
	logic      download_end;
	sd_lba_t   last_lba;

	// Autosave fires once the OSD opens
	assign save_eff = save_req | (bk_pending & osd_status & autosave_en);
	assign load_rise = load_s & ~load_d;
	assign save_rise = save_s & ~save_d;
	assign download_end = old_download & ~cart_download & (|img_size) & bk_ena;
	assign last_lba = sd_lba_t'(ram_mask >> SECTOR_SHIFT);
	assign bk_busy = (state == BK_TRANSFER);

	// ==============================
	// Enable and pending flags
	// ==============================

	// Save image is mounted by the end of the download
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_download <= 1'b0;
			bk_ena <= 1'b0;
		end else begin
			old_download <= cart_download;
			if (!old_download && cart_download) begin
				bk_ena <= 1'b0;
			end
			if (cart_download && img_mounted && !img_readonly) begin
				bk_ena <= |ram_mask;
			end
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			bk_pending <= 1'b0;
		end else if (bk_ena && !osd_status && bsram_write) begin
			bk_pending <= 1'b1;
		end else if (state == BK_TRANSFER) begin
			bk_pending <= 1'b0;
		end
	end

	// Request levels go through one register before edge detection
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			load_s <= 1'b0;
			load_d <= 1'b0;
			save_s <= 1'b0;
			save_d <= 1'b0;
			ack_d <= 1'b0;
		end else begin
			load_s <= load_req & bk_ena;
			load_d <= load_s;
			save_s <= save_eff & bk_ena;
			save_d <= save_s;
			ack_d <= sd_ack;
		end
	end

	// ==============================
	// Sector sequencer
	// ==============================

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state <= BK_IDLE;
			bk_loading <= 1'b0;
			sd_rd <= 1'b0;
			sd_wr <= 1'b0;
			sd_lba <= '0;
		end else begin
			// Host took the request
			if (sd_ack && !ack_d) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				BK_IDLE: begin
					if (load_rise || save_rise) begin
						bk_loading <= load_rise;
						sd_lba <= '0;
						sd_rd <= load_rise;
						sd_wr <= ~load_rise;
						state <= BK_TRANSFER;
					end
					// Fresh cartridge pulls its save in
					if (download_end) begin
						bk_loading <= 1'b1;
						sd_lba <= '0;
						sd_rd <= 1'b1;
						sd_wr <= 1'b0;
						state <= BK_TRANSFER;
					end
				end
				BK_TRANSFER: begin
					// Falling ack ends one sector
					if (ack_d && !sd_ack) begin
						if (sd_lba >= last_lba) begin
							bk_loading <= 1'b0;
							state <= BK_IDLE;
						end else begin
							sd_lba <= sd_lba + sd_lba_t'(1);
							sd_rd <= bk_loading;
							sd_wr <= ~bk_loading;
						end
					end
				end
			endcase
		end
	end

endmodule

// File: verilog/cheat_code_loader.sv
`timescale 1ns/1ps

module cheat_code_loader
	import host_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        code_download,
	input  logic        dl_wr,
	input  dl_addr_t    dl_addr,
	input  dl_word_t    dl_data,
	output cheat_code_t cheat_code,
	output logic        code_valid
);

	logic code_wr;

	assign code_wr = code_download & dl_wr;

	// ==============================
	// Record assembly
	// ==============================

	// 16-byte record, bottom half of each field comes first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl_addr[3:0])
				4'd0:  cheat_code[111:96]  <= dl_data;
				4'd2:  cheat_code[127:112] <= dl_data;
				4'd4:  cheat_code[79:64]   <= dl_data;
				4'd6:  cheat_code[95:80]   <= dl_data;
				4'd8:  cheat_code[47:32]   <= dl_data;
				4'd10: cheat_code[63:48]   <= dl_data;
				4'd12: cheat_code[15:0]    <= dl_data;
				4'd14: cheat_code[31:16]   <= dl_data;
				default: ;
			endcase
		end
	end

	// Last word of the record loads the code
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			code_valid <= 1'b0;
		end else begin
			code_valid <= code_wr && (dl_addr[3:0] == 4'd14);
		end
	end

endmodule

// File: verilog/rom_header_decode.sv
`timescale 1ns/1ps

module rom_header_decode
	import cart_pkg::*;
	import host_pkg::*;
(
	input  logic          clk_sys,
	input  logic          reset,
	input  logic          cart_download,
	input  logic          dl_wr,
	input  dl_addr_t      dl_addr,
	input  dl_word_t      dl_data,
	input  rom_layout_t   layout,
	input  video_region_t region_sel,
	output rom_type_t     rom_type,
	output cart_mask_t    rom_mask,
	output cart_mask_t    ram_mask,
	output logic          pal
);

	size_code_t rom_size;
	size_code_t ram_size;
	logic       region_bit;
	logic       forced_hdr;
	dl_addr_t   rom_size_addr;
	dl_addr_t   ram_size_addr;

	// Where the forced layout keeps its size bytes in the download
	always_comb begin
		forced_hdr = 1'b1;
		rom_size_addr = dl_addr_t'(HDR_LOROM_SIZE + COPIER_HEADER_BYTES);
		case (layout)
			LAYOUT_LOROM:   rom_size_addr = dl_addr_t'(HDR_LOROM_SIZE + COPIER_HEADER_BYTES);
			LAYOUT_HIROM:   rom_size_addr = dl_addr_t'(HDR_HIROM_SIZE + COPIER_HEADER_BYTES);
			LAYOUT_EXHIROM: rom_size_addr = dl_addr_t'(HDR_EXHIROM_SIZE + COPIER_HEADER_BYTES);
			default:        forced_hdr = 1'b0;
		endcase
		ram_size_addr = rom_size_addr + dl_addr_t'(HDR_RAM_OFFSET);
	end

	// ==============================
	// Header capture
	// ==============================

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			rom_size <= DEFAULT_ROM_SIZE;
			ram_size <= '0;
			rom_type <= '0;
			region_bit <= 1'b0;
		end else if (cart_download && dl_wr) begin
			if (dl_addr == dl_addr_t'(HDR_INFO_ADDR)) begin
				rom_size <= DEFAULT_ROM_SIZE;
				ram_size <= '0;
				case (layout)
					LAYOUT_AUTO: begin
						rom_type <= dl_data[15:8];
						// Zero size byte keeps the defaults
						if (dl_data[7:0] != 8'd0) begin
							rom_size <= dl_data[3:0];
							ram_size <= dl_data[7:4];
						end
					end
					LAYOUT_NO_HEADER,
					LAYOUT_LOROM:   rom_type <= ROM_TYPE_LOROM;
					LAYOUT_HIROM:   rom_type <= ROM_TYPE_HIROM;
					LAYOUT_EXHIROM: rom_type <= ROM_TYPE_EXHIROM;
					default:        rom_type <= dl_data[15:8];
				endcase
			end

			if (dl_addr == dl_addr_t'(HDR_REGION_ADDR)) begin
				region_bit <= dl_data[HDR_REGION_BIT];
			end

			// Internal header of a forced layout
			if (forced_hdr && dl_addr == rom_size_addr) begin
				rom_size <= dl_data[11:8];
			end
			if (forced_hdr && dl_addr == ram_size_addr) begin
				ram_size <= dl_data[3:0];
			end
		end
	end

	assign rom_mask = (KB_SHIFT_BASE << rom_size) - cart_mask_t'(1);
	assign ram_mask = (ram_size != '0) ? (KB_SHIFT_BASE << ram_size) - cart_mask_t'(1) : '0;

	// Region only changes outside a download
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			pal <= 1'b0;
		end else if (!cart_download) begin
			if (region_sel == REGION_AUTO) begin
				pal <= region_bit;
			end else begin
				pal <= (region_sel == REGION_PAL);
			end
		end
	end

endmodule

// File: verilog/host_pkg.sv
package host_pkg;

	// ==============================
	// Download stream
	// ==============================

	typedef logic [24:0] dl_addr_t;
	typedef logic [15:0] dl_word_t;
	typedef logic [7:0]  dl_index_t;

	// All-ones index marks a cheat download
	localparam dl_index_t CODE_INDEX = 8'hFF;

	// Cheat record, big fields first
	// flags 127:96, address 95:64, compare 63:32, replace 31:0
	typedef logic [127:0] cheat_code_t;

	// ==============================
	// SD image sectors
	// ==============================

	typedef logic [31:0] sd_lba_t;

	// 512-byte sectors
	localparam int unsigned SECTOR_SHIFT = 9;

	typedef enum logic {
		BK_IDLE     = 1'b0,
		BK_TRANSFER = 1'b1
	} bk_state_t;

endpackage

// File: verilog/cart_pkg.sv
package cart_pkg;

	// ==============================
	// Menu choices
	// ==============================

	typedef enum logic [2:0] {
		LAYOUT_AUTO      = 3'd0,
		LAYOUT_NO_HEADER = 3'd1,
		LAYOUT_LOROM     = 3'd2,
		LAYOUT_HIROM     = 3'd3,
		LAYOUT_EXHIROM   = 3'd4
	} rom_layout_t;

	typedef enum logic [1:0] {
		REGION_AUTO = 2'd0,
		REGION_NTSC = 2'd1,
		REGION_PAL  = 2'd2
	} video_region_t;

	// Header field types
	typedef logic [3:0]  size_code_t;
	typedef logic [23:0] cart_mask_t;
	typedef logic [7:0]  rom_type_t;

	// ==============================
	// Header layout
	// ==============================

	// Every internal header address is shifted by the copier header
	localparam int unsigned COPIER_HEADER_BYTES = 512;
	localparam int unsigned HDR_LOROM_SIZE      = 'h7FD6;
	localparam int unsigned HDR_HIROM_SIZE      = 'hFFD6;
	localparam int unsigned HDR_EXHIROM_SIZE    = 'h40FFD6;
	localparam int unsigned HDR_RAM_OFFSET      = 2;
	localparam int unsigned HDR_INFO_ADDR       = 0;
	localparam int unsigned HDR_REGION_ADDR     = 2;
	localparam int unsigned HDR_REGION_BIT      = 8;

	// Size in bytes is 1 KB shifted left by the code
	localparam size_code_t DEFAULT_ROM_SIZE = 4'd12;
	localparam cart_mask_t KB_SHIFT_BASE    = 24'd1024;

	// Mapper types set by the forced layouts
	localparam rom_type_t ROM_TYPE_LOROM   = 8'd0;
	localparam rom_type_t ROM_TYPE_HIROM   = 8'd1;
	localparam rom_type_t ROM_TYPE_EXHIROM = 8'd2;

endpackage
